//--- all.f
design/fetch_pkg.sv
design/pc_fetch.sv
design/data_port.sv
design/wb_arbiter.sv
design/shared_mem.sv
design/fetch_subsys.sv
tb/fetch_subsys_sva.sv
tb/fetch_subsys_tb.sv

//--- design/data_port.sv
// load/store port of the core onto the shared Wishbone bus
// accepts one request while idle and runs a single bus cycle with it
// drsp_valid pulses for one cycle with the read data, zero for a store

`timescale 1ns/100ps

module data_port (
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic                    dreq_valid,
   input  fetch_pkg::dreq_t        dreq,
   output logic                    dreq_ready,
   output logic                    drsp_valid,
   output logic [fetch_pkg::word_w-1:0] drsp_data,
   output fetch_pkg::wb_req_t      wb_req,
   input  fetch_pkg::wb_rsp_t      wb_rsp
);
   import fetch_pkg::*;

   typedef enum logic [1:0] {
      st_idle,
      st_bus,
      st_resp
   } state_t;

   state_t            state;
   dreq_t             req_q;
   logic [word_w-1:0] rdata_q;

   // one request outstanding at most
   assign dreq_ready = (state == st_idle);
   assign drsp_valid = (state == st_resp);
   assign drsp_data  = rdata_q;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= st_idle;
      end else begin
         case (state)
            st_idle: if (dreq_valid) state <= st_bus;
            st_bus:  if (wb_rsp.ack) state <= st_resp;
            // response lasts a single cycle
            st_resp: state <= st_idle;
            default: state <= st_idle;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (dreq_valid && dreq_ready) begin
         req_q <= dreq;
      end
      if (state == st_bus && wb_rsp.ack) begin
         rdata_q <= req_q.we ? '0 : wb_rsp.dat;
      end
   end

   always_comb begin
      wb_req.cyc = (state == st_bus);
      wb_req.stb = (state == st_bus);
      wb_req.we  = req_q.we;
      wb_req.adr = req_q.addr;
      wb_req.dat = req_q.wdata;
   end

endmodule

//--- design/fetch_pkg.sv
// shared types and sizes for the instruction-fetch subsystem
// every module imports this package in its body and uses scoped names
// in its port list
// bus links follow Wishbone classic, one request struct per master

package fetch_pkg;

   // data and address width of the core
   localparam int word_w = 16;
   // on-chip memory size in 16-bit words
   localparam int mem_depth = 256;
   // word index width, taken from address bits 8:1
   localparam int mem_aw = 8;

   // master to slave side of a Wishbone classic link
   typedef struct packed {
      logic              cyc;
      logic              stb;
      logic              we;
      logic [word_w-1:0] adr;
      logic [word_w-1:0] dat;
   } wb_req_t;

   // slave to master side
   typedef struct packed {
      logic              ack;
      logic [word_w-1:0] dat;
   } wb_rsp_t;

   // next-PC control sampled at the instruction handshake
   typedef struct packed {
      logic              jump;
      // register-relative jump when set together with jump
      logic              jump_reg;
      logic              br_taken;
      logic [word_w-1:0] reg_val;
      // sign-extended offset, already scaled by the decoder
      logic [word_w-1:0] ext_val;
   } redirect_t;

   // one fetched instruction with its addresses
   typedef struct packed {
      logic [word_w-1:0] instr;
      logic [word_w-1:0] pc;
      logic [word_w-1:0] pc_plus2;
   } instr_t;

   // load or store request from the core
   typedef struct packed {
      logic              we;
      logic [word_w-1:0] addr;
      logic [word_w-1:0] wdata;
   } dreq_t;

endpackage

//--- design/fetch_subsys.sv
// top of the fetch subsystem
// fetch unit on arbiter port 0, data port on port 1, one shared memory
// behind the arbiter, no logic of its own here

`timescale 1ns/100ps

module fetch_subsys (
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic                    run,
   input  logic                    halt,
   input  logic                    instr_ready,
   input  fetch_pkg::redirect_t    redirect,
   output logic                    instr_valid,
   output fetch_pkg::instr_t       instr_out,
   output logic                    halted,
   input  logic                    dreq_valid,
   input  fetch_pkg::dreq_t        dreq,
   output logic                    dreq_ready,
   output logic                    drsp_valid,
   output logic [fetch_pkg::word_w-1:0] drsp_data
);
   import fetch_pkg::*;

   // fetch link, data link and the slave link
   wb_req_t f_req;
   wb_rsp_t f_rsp;
   wb_req_t d_req;
   wb_rsp_t d_rsp;
   wb_req_t s_req;
   wb_rsp_t s_rsp;

   pc_fetch fetch_i (
      .clk         (clk),
      .rst_n       (rst_n),
      .run         (run),
      .halt        (halt),
      .instr_ready (instr_ready),
      .redirect    (redirect),
      .instr_valid (instr_valid),
      .halted      (halted),
      .instr_out   (instr_out),
      .wb_req      (f_req),
      .wb_rsp      (f_rsp)
   );

   data_port dport_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .dreq_valid (dreq_valid),
      .dreq       (dreq),
      .dreq_ready (dreq_ready),
      .drsp_valid (drsp_valid),
      .drsp_data  (drsp_data),
      .wb_req     (d_req),
      .wb_rsp     (d_rsp)
   );

   // port 0 is fetch, it wins the first tie after reset
   wb_arbiter arb_i (
      .clk    (clk),
      .rst_n  (rst_n),
      .m0_req (f_req),
      .m1_req (d_req),
      .m0_rsp (f_rsp),
      .m1_rsp (d_rsp),
      .s_req  (s_req),
      .s_rsp  (s_rsp)
   );

   shared_mem mem_i (
      .clk    (clk),
      .rst_n  (rst_n),
      .wb_req (s_req),
      .wb_rsp (s_rsp)
   );

endmodule

//--- design/pc_fetch.sv
// fetch unit that holds the PC and reads instructions over Wishbone
// an instruction is offered with valid/ready and the redirect is applied
// at the handshake, halt at the handshake stops further fetches
// fetches only start while run is high

`timescale 1ns/100ps

module pc_fetch (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 run,
   input  logic                 halt,
   input  logic                 instr_ready,
   input  fetch_pkg::redirect_t redirect,
   output logic                 instr_valid,
   output logic                 halted,
   output fetch_pkg::instr_t    instr_out,
   output fetch_pkg::wb_req_t   wb_req,
   input  fetch_pkg::wb_rsp_t   wb_rsp
);
   import fetch_pkg::*;

   typedef enum logic [1:0] {
      st_idle,
      st_bus,
      st_hold
   } state_t;

   state_t            state;
   logic [word_w-1:0] pc_q;
   logic [word_w-1:0] pc_plus2;
   logic [word_w-1:0] next_pc;
   logic [word_w-1:0] br_tgt;
   logic [word_w-1:0] reg_tgt;
   logic [word_w-1:0] instr_q;
   logic              hshake;

   assign pc_plus2 = pc_q + word_w'(2);
   // pc relative target shared by taken branch and immediate jump
   assign br_tgt   = pc_plus2 + redirect.ext_val;
   assign reg_tgt  = redirect.reg_val + redirect.ext_val;

   // jump wins over branch
   always_comb begin
      if (redirect.jump) begin
         next_pc = redirect.jump_reg ? reg_tgt : br_tgt;
      end else if (redirect.br_taken) begin
         next_pc = br_tgt;
      end else begin
         next_pc = pc_plus2;
      end
   end

   assign instr_valid = (state == st_hold);
   // low instr_ready is the stall, nothing moves
   assign hshake      = instr_valid && instr_ready;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state  <= st_idle;
         pc_q   <= '0;
         halted <= 1'b0;
      end else begin
         case (state)
            st_idle: begin
               // wait here for run, a halted core never leaves
               if (run && !halted) begin
                  state <= st_bus;
               end
            end
            st_bus: begin
               if (wb_rsp.ack) begin
                  state <= st_hold;
               end
            end
            st_hold: begin
               if (hshake) begin
                  pc_q  <= next_pc;
                  state <= st_idle;
                  if (halt) begin
                     halted <= 1'b1;
                  end
               end
            end
            default: state <= st_idle;
         endcase
      end
   end

   // instruction word captured on ack
   always_ff @(posedge clk) begin
      if (state == st_bus && wb_rsp.ack) begin
         instr_q <= wb_rsp.dat;
      end
   end

   // read-only master whose address stays stable for the whole cycle
   always_comb begin
      wb_req.cyc = (state == st_bus);
      wb_req.stb = (state == st_bus);
      wb_req.we  = 1'b0;
      wb_req.adr = pc_q;
      wb_req.dat = '0;
   end

   assign instr_out = '{instr: instr_q, pc: pc_q, pc_plus2: pc_plus2};

endmodule

//--- design/shared_mem.sv
// 256 x 16 on-chip memory as a Wishbone classic slave
// ack and read data are registered, ack lasts one cycle per request
// word addressed by adr[8:1], writes land in the ack cycle

`timescale 1ns/100ps

module shared_mem (
   input  logic               clk,
   input  logic               rst_n,
   input  fetch_pkg::wb_req_t wb_req,
   output fetch_pkg::wb_rsp_t wb_rsp
);
   import fetch_pkg::*;

   logic [word_w-1:0] mem [mem_depth];
   logic [word_w-1:0] rdata_q;
   logic [mem_aw-1:0] idx;
   logic              ack_q;
   logic              access;

   assign idx    = wb_req.adr[mem_aw:1];
   // new request only when the previous ack has gone
   assign access = wb_req.cyc && wb_req.stb && !ack_q;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= access;
      end
   end

   // array and read register carry no reset
   always_ff @(posedge clk) begin
      if (access) begin
         if (wb_req.we) begin
            mem[idx] <= wb_req.dat;
         end
         rdata_q <= mem[idx];
      end
   end

   assign wb_rsp = '{ack: ack_q, dat: rdata_q};

endmodule

//--- design/wb_arbiter.sv
// two-master round-robin arbiter in front of one Wishbone slave
// a free bus is granted combinationally in the cycle cyc rises and the
// grant is held until the slave acks, then priority swaps
// the master without the grant never sees ack

`timescale 1ns/100ps

module wb_arbiter (
   input  logic               clk,
   input  logic               rst_n,
   input  fetch_pkg::wb_req_t m0_req,
   input  fetch_pkg::wb_req_t m1_req,
   output fetch_pkg::wb_rsp_t m0_rsp,
   output fetch_pkg::wb_rsp_t m1_rsp,
   output fetch_pkg::wb_req_t s_req,
   input  fetch_pkg::wb_rsp_t s_rsp
);
   import fetch_pkg::*;

   // 0 selects m0, 1 selects m1
   logic gnt_q;
   logic gnt_c;
   logic gnt;
   logic busy;
   // master favoured when both ask in the same cycle
   logic prio;

   // pick a master for a free bus
   always_comb begin
      if (m0_req.cyc && m1_req.cyc) begin
         gnt_c = prio;
      end else begin
         gnt_c = m1_req.cyc;
      end
   end

   // locked grant while a cycle is in flight
   assign gnt = busy ? gnt_q : gnt_c;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         busy  <= 1'b0;
         gnt_q <= 1'b0;
         // fetch has priority out of reset
         prio  <= 1'b0;
      end else if (s_rsp.ack) begin
         // cycle done, master drops cyc next, other side goes first
         busy <= 1'b0;
         prio <= ~gnt;
      end else if (!busy && (m0_req.cyc || m1_req.cyc)) begin
         busy  <= 1'b1;
         gnt_q <= gnt_c;
      end
   end

   assign s_req = gnt ? m1_req : m0_req;

   // read data fans out, only ack is steered
   always_comb begin
      m0_rsp.dat = s_rsp.dat;
      m1_rsp.dat = s_rsp.dat;
      m0_rsp.ack = s_rsp.ack && !gnt;
      m1_rsp.ack = s_rsp.ack && gnt;
   end

endmodule

//--- tb/fetch_subsys_sva.sv
// bus checks bound into the arbiter
// every slave ack reaches one master that is requesting, never comes
// without a request on the slave side, and a waiting fetch request
// holds still until its ack

`timescale 1ns/100ps

module fetch_subsys_sva (
   input logic               clk,
   input logic               rst_n,
   input fetch_pkg::wb_req_t m0_req,
   input fetch_pkg::wb_req_t m1_req,
   input fetch_pkg::wb_rsp_t m0_rsp,
   input fetch_pkg::wb_rsp_t m1_rsp,
   input fetch_pkg::wb_req_t s_req,
   input fetch_pkg::wb_rsp_t s_rsp
);
   import fetch_pkg::*;

   // failed assertions so far, read by the testbench at the end
   int fail_count = 0;

   // slave ack goes to exactly one master and that master holds cyc
   ack_owner: assert property (@(posedge clk) disable iff (!rst_n)
      s_rsp.ack |-> (m0_rsp.ack ? m0_req.cyc : (m1_rsp.ack && m1_req.cyc)))
      else begin
         fail_count++;
         $error("ack routed to a master without a cycle");
      end

   // slave ack only inside a live cycle
   ack_in_cycle: assert property (@(posedge clk) disable iff (!rst_n)
      s_rsp.ack |-> (s_req.cyc && s_req.stb))
      else begin
         fail_count++;
         $error("ack without cyc and stb");
      end

   // fetch master stalled on the bus keeps its request
   fetch_stable: assert property (@(posedge clk) disable iff (!rst_n)
      (m0_req.cyc && !m0_rsp.ack) |=> (m0_req.cyc && $stable(m0_req)))
      else begin
         fail_count++;
         $error("fetch request changed before ack");
      end

endmodule

bind wb_arbiter fetch_subsys_sva sva_i (
   .clk    (clk),
   .rst_n  (rst_n),
   .m0_req (m0_req),
   .m1_req (m1_req),
   .m0_rsp (m0_rsp),
   .m1_rsp (m1_rsp),
   .s_req  (s_req),
   .s_rsp  (s_rsp)
);

//--- tb/fetch_subsys_tb.sv
// directed testbench for the fetch subsystem
// fills memory over the data port, then runs sequential fetch, redirects,
// stall and halt, and fetch with data loads sharing the bus
// expected values come from a memory model and the next-PC rules

`timescale 1ns/100ps

module fetch_subsys_tb;
   import fetch_pkg::*;

   logic              clk;
   logic              rst_n;
   logic              run;
   logic              halt;
   logic              instr_ready;
   redirect_t         redirect;
   logic              instr_valid;
   instr_t            instr_out;
   logic              halted;
   logic              dreq_valid;
   dreq_t             dreq;
   logic              dreq_ready;
   logic              drsp_valid;
   logic [word_w-1:0] drsp_data;

   // expected memory contents indexed like the DUT by address bits 8:1
   logic [word_w-1:0] model [mem_depth];
   logic [word_w-1:0] t1_addr [8];
   logic [word_w-1:0] exp_pc;
   integer            seed = 32'hac60;
   int                cycles = 0;
   // 16 + 32 program stores + 6 + 5 + 1 + 16
   int                req_total = 76;

   fetch_subsys dut_i (
      .clk         (clk),
      .rst_n       (rst_n),
      .run         (run),
      .halt        (halt),
      .instr_ready (instr_ready),
      .redirect    (redirect),
      .instr_valid (instr_valid),
      .instr_out   (instr_out),
      .halted      (halted),
      .dreq_valid  (dreq_valid),
      .dreq        (dreq),
      .dreq_ready  (dreq_ready),
      .drsp_valid  (drsp_valid),
      .drsp_data   (drsp_data)
   );

   initial clk = 1'b0;
   always #5 clk = ~clk;

   // watchdog allows 20 cycles per bus request
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= req_total * 20) begin
         $display("timeout, tests did not finish within %0d cycles", req_total * 20);
         $display("Something failed");
         $fatal(1, "run stopped by the watchdog");
      end
   end

   // step to just after the next rising edge, outputs are settled there
   task automatic tick();
      @(posedge clk);
      #1;
   endtask

   task automatic check(input string what, input logic [47:0] got, input logic [47:0] exp);
      if (got !== exp) begin
         $display("mismatch at %0t ns: %s, got %h expected %h", $time, what, got, exp);
         $display("Something failed");
         $fatal(1, "check failed");
      end
   endtask

   task automatic apply_reset();
      rst_n = 1'b0;
      repeat (8) @(posedge clk);
      #1;
      rst_n = 1'b1;
   endtask

   // program word pattern that depends on every address bit
   function automatic logic [word_w-1:0] fill_word(input logic [word_w-1:0] a);
      return (a * 16'h0c35) ^ {a[7:0], a[15:8]};
   endfunction

   function automatic redirect_t make_redirect(input logic jump, input logic jump_reg,
                                               input logic br, input logic [word_w-1:0] rv,
                                               input logic [word_w-1:0] ev);
      return '{jump: jump, jump_reg: jump_reg, br_taken: br, reg_val: rv, ext_val: ev};
   endfunction

   // next PC from the redirect rules with jump before branch
   function automatic logic [word_w-1:0] expected_next_pc(input logic [word_w-1:0] pc,
                                                          input redirect_t rd);
      if (rd.jump && rd.jump_reg) begin
         return rd.reg_val + rd.ext_val;
      end else if (rd.jump || rd.br_taken) begin
         return pc + 16'd2 + rd.ext_val;
      end
      return pc + 16'd2;
   endfunction

   // one load or store that waits for ready and for the response pulse
   task automatic data_access(input logic we, input logic [word_w-1:0] addr,
                              input logic [word_w-1:0] wdata,
                              output logic [word_w-1:0] rdata);
      while (!dreq_ready) tick();
      dreq_valid = 1'b1;
      dreq = '{we: we, addr: addr, wdata: wdata};
      tick();
      dreq_valid = 1'b0;
      // port stays busy until the response
      check("dreq_ready while busy", dreq_ready, 1'b0);
      while (!drsp_valid) tick();
      rdata = drsp_data;
      tick();
      // response is a single-cycle pulse and the port is free again
      check("drsp_valid pulse length", drsp_valid, 1'b0);
      check("dreq_ready after response", dreq_ready, 1'b1);
   endtask

   task automatic store_word(input logic [word_w-1:0] addr, input logic [word_w-1:0] data);
      logic [word_w-1:0] rd;
      data_access(1'b1, addr, data, rd);
      // a store answers with zero
      check("store response", rd, 16'h0000);
      model[addr[mem_aw:1]] = data;
   endtask

   task automatic load_and_compare(input logic [word_w-1:0] addr);
      logic [word_w-1:0] rd;
      data_access(1'b0, addr, 16'h0000, rd);
      check("load data", rd, model[addr[mem_aw:1]]);
   endtask

   // takes the offered instruction, checks it and applies a redirect
   task automatic expect_fetch(input redirect_t rd, input logic hlt);
      instr_t got;
      while (!instr_valid) tick();
      got = instr_out;
      check("fetched pc", got.pc, exp_pc);
      check("fetched instr", got.instr, model[exp_pc[mem_aw:1]]);
      check("pc_plus2", got.pc_plus2, exp_pc + 16'd2);
      redirect = rd;
      halt = hlt;
      instr_ready = 1'b1;
      tick();
      instr_ready = 1'b0;
      halt = 1'b0;
      redirect = '0;
      exp_pc = expected_next_pc(exp_pc, rd);
   endtask

   task automatic store_and_read_back();
      for (int i = 0; i < 8; i++) begin
         t1_addr[i] = 16'h0180 + 16'(i * 6);
         store_word(t1_addr[i], 16'($random(seed)));
      end
      for (int i = 0; i < 8; i++) begin
         load_and_compare(t1_addr[i]);
      end
   endtask

   // 32 words from address 0 up
   task automatic load_program();
      for (int i = 0; i < 32; i++) begin
         store_word(16'(i * 2), fill_word(16'(i * 2)));
      end
   endtask

   task automatic run_sequential_fetch();
      exp_pc = 16'h0000;
      run = 1'b1;
      repeat (6) expect_fetch('0, 1'b0);
   endtask

   task automatic apply_redirects();
      // offset ignored without jump or branch
      expect_fetch(make_redirect(1'b0, 1'b0, 1'b0, 16'h0000, 16'h0040), 1'b0);
      expect_fetch(make_redirect(1'b0, 1'b0, 1'b1, 16'h0000, 16'h0008), 1'b0);
      // backwards immediate jump
      expect_fetch(make_redirect(1'b1, 1'b0, 1'b0, 16'h0000, 16'hfff0), 1'b0);
      expect_fetch(make_redirect(1'b1, 1'b1, 1'b0, 16'h0020, 16'h0004), 1'b0);
      expect_fetch('0, 1'b0);
   endtask

   task automatic stall_then_halt();
      instr_t held;
      while (!instr_valid) tick();
      held = instr_out;
      repeat (6) begin
         tick();
         check("valid under stall", instr_valid, 1'b1);
         check("instr_out under stall", instr_out, held);
      end
      expect_fetch('0, 1'b1);
      check("halted after halt", halted, 1'b1);
      repeat (12) begin
         tick();
         check("valid after halt", instr_valid, 1'b0);
         check("halted held", halted, 1'b1);
      end
   endtask

   // fetch and data loads compete for the memory
   task automatic share_bus_with_loads();
      run = 1'b0;
      apply_reset();
      exp_pc = 16'h0000;
      run = 1'b1;
      fork
         repeat (8) expect_fetch('0, 1'b0);
         for (int i = 0; i < 8; i++) begin
            load_and_compare((i % 2) ? t1_addr[i] : 16'(i * 4));
         end
      join
   endtask

   initial begin
      run         = 1'b0;
      halt        = 1'b0;
      instr_ready = 1'b0;
      redirect    = '0;
      dreq_valid  = 1'b0;
      dreq        = '0;
      apply_reset();
      store_and_read_back();
      load_program();
      run_sequential_fetch();
      apply_redirects();
      stall_then_halt();
      share_bus_with_loads();
      // bound bus assertions count their own failures
      if (dut_i.arb_i.sva_i.fail_count == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule
